// ==== pzx_player_top.f ====
pzx_pkg.sv
sram_port_if.sv
sram_access.sv
pulse_timer.sv
pzx_sequencer.sv
pzx_player_top.sv
tb_pzx_player.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pzx_player_top.f --top-module tb_pzx_player \
    && ./obj_dir/Vtb_pzx_player | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_pzx_player.sv ====
`timescale 1ns/10ps

module tb_pzx_player;
    import pzx_pkg::*;

    localparam int TCLKS = 2;

    logic       clk;
    logic       rst_n;
    byte_t      host_addr;
    byte_t      host_wdata;
    byte_t      host_rdata;
    logic       host_rd;
    logic       host_wr;
    logic       oe_n;
    logic       play_in;
    logic       stop_in;
    logic       pulse_out;
    logic       playing;
    sram_addr_t mem_addr;
    logic       mem_we_n;
    byte_t      mem_wdata;
    byte_t      mem_rdata;

    int          errors = 0;
    int          checks = 0;
    int          err_start = 0;
    logic [31:0] lfsr_q = 32'd73012;
    int          cyc = 0;
    int          last_edge_cyc = 0;
    logic        prev_level = 1'b0;
    logic        mon_en = 1'b0;
    int          exp_level[$];
    int          exp_gap[$];      // -1 where the gap is not fixed
    int          ent_count[$];
    int          ent_dur[$];
    byte_t       body[$];
    int          wr_ptr = 0;

    pzx_player_top #(.TSTATE_CLKS(TCLKS)) pzx_player_top_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------
    // SRAM model
    // ------------------------------
    byte_t sram [0:4095];

    function automatic byte_t fill_byte(input sram_addr_t a);
        return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]} ^ 8'h5A;
    endfunction

    assign mem_rdata = mem_addr < 21'd4096 ? sram[mem_addr[11:0]] : fill_byte(mem_addr);

    always @(posedge clk) begin
        if (!mem_we_n && mem_addr < 21'd4096)
            sram[mem_addr[11:0]] <= mem_wdata;
    end

    // ------------------------------
    // Checks and reference model
    // ------------------------------
    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_gap(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL t=%0t %s got %0d expected %0d clocks", $time, name, got, exp);
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = (r << 1) | int'(lfsr_q[0]);
        end
        return r;
    endfunction

    // Expected edges of a PULSE block, level starts low
    function automatic void expand_pulses();
        logic lvl;
        lvl = 1'b0;
        exp_level.delete();
        exp_gap.delete();
        foreach (ent_count[i]) begin
            if (ent_dur[i] == 0) begin
                if (ent_count[i] % 2 == 1) begin   // Odd count flips once
                    lvl = ~lvl;
                    exp_level.push_back(int'(lvl));
                    exp_gap.push_back(-1);
                end
            end else begin
                for (int k = 0; k < ent_count[i]; k++) begin
                    lvl = ~lvl;
                    exp_level.push_back(int'(lvl));
                    exp_gap.push_back(k == 0 ? -1 : ent_dur[i] * TCLKS);
                end
            end
        end
    endfunction

    // Edge monitor, sampled away from the active edge
    always @(negedge clk) begin : edge_monitor
        int el;
        int eg;
        cyc = cyc + 1;
        if (rst_n && pulse_out !== prev_level) begin
            if (mon_en) begin
                if (exp_level.size() == 0) begin
                    errors++;
                    $display("Unexpected extra edge on pulse_out at %0t", $time);
                end else begin
                    el = exp_level.pop_front();
                    eg = exp_gap.pop_front();
                    check_level("pulse_out", pulse_out, el[0]);
                    if (eg >= 0)
                        check_gap("pulse interval", cyc - last_edge_cyc, eg);
                end
            end
            last_edge_cyc = cyc;
            prev_level = pulse_out;
        end
    end

    // ------------------------------
    // Host and control drivers
    // ------------------------------
    task automatic host_write(input byte_t reg_n, input byte_t data);
        logic exp_we_n;
        exp_we_n   = !(reg_n == REG_SRAM_DATA || reg_n == REG_SRAM_ADDR_INC);  // Data regs only
        host_addr  = reg_n;
        host_wdata = data;
        host_wr    = 1'b1;
        #40;
        check_level("mem_we_n", mem_we_n, exp_we_n);
        check_level("oe_n", oe_n, 1'b1);
        check_byte("mem_wdata", mem_wdata, data);
        @(posedge clk); #5;
        host_wr = 1'b0;
        repeat (3) @(posedge clk);
        #5;
    endtask

    task automatic host_read(input byte_t reg_n, output byte_t data);
        host_addr = reg_n;
        host_rd   = 1'b1;
        #40;
        data = host_rdata;
        check_level("oe_n", oe_n, 1'b0);
        check_level("mem_we_n", mem_we_n, 1'b1);
        @(posedge clk); #5;
        host_rd = 1'b0;
        repeat (3) @(posedge clk);
        #5;
    endtask

    task automatic set_addr(input int a);
        host_write(REG_SRAM_ADDR, byte_t'((a >> 16) & 255));
        host_write(REG_SRAM_ADDR, byte_t'((a >> 8) & 255));
        host_write(REG_SRAM_ADDR, byte_t'(a & 255));
        wr_ptr = a;
    endtask

    task automatic put_word(input int w);
        body.push_back(byte_t'(w & 255));
        body.push_back(byte_t'((w >> 8) & 255));
    endtask

    // Tag, 32-bit length LSB first, then the body
    task automatic emit_block(input byte_t tag);
        int n;
        n = body.size();
        host_write(REG_SRAM_ADDR_INC, tag);
        for (int i = 0; i < 4; i++)
            host_write(REG_SRAM_ADDR_INC, byte_t'((n >> (8 * i)) & 255));
        foreach (body[i])
            host_write(REG_SRAM_ADDR_INC, body[i]);
        wr_ptr += 5 + n;
        body.delete();
    endtask

    task automatic pause_body(input logic lvl, input int d);
        put_word(d & 16'hFFFF);
        put_word((int'(lvl) << 15) | ((d >> 16) & 16'h7FFF));
    endtask

    task automatic press_play();
        play_in = 1'b1;
        @(posedge clk); #5;
        play_in = 1'b0;
    endtask

    task automatic press_stop();
        stop_in = 1'b1;
        @(posedge clk); #5;
        stop_in = 1'b0;
    endtask

    task automatic wait_playing(input logic val, input int limit, input string what);
        int n;
        n = 0;
        while (playing !== val && n < limit) begin
            @(posedge clk); #5;
            n++;
        end
        if (playing !== val) begin
            errors++;
            $display("Timeout after %0d clocks waiting for %s", limit, what);
        end
    endtask

    task automatic wait_pulse(input logic val, input int limit, input string what);
        int n;
        n = 0;
        while (pulse_out !== val && n < limit) begin
            @(posedge clk); #5;
            n++;
        end
        if (pulse_out !== val) begin
            errors++;
            $display("Timeout after %0d clocks waiting for %s", limit, what);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s (%0d errors)", name, errors == err_start ? "ok" : "failed",
                 errors - err_start);
        err_start = errors;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        byte_t ab[3];
        byte_t wb[4];
        byte_t rd;
        int    exp_a;
        int    limit;
        int    d;
        int    next_addr;

        rst_n = 1'b0;
        host_addr = 8'h00;
        host_wdata = 8'h00;
        host_rd = 1'b0;
        host_wr = 1'b0;
        play_in = 1'b0;
        stop_in = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(posedge clk); #5;

        // Host access
        ab = '{8'hE0, 8'h01, 8'h2C};
        exp_a = 0;
        foreach (ab[i]) begin
            host_write(REG_SRAM_ADDR, ab[i]);
            exp_a = ((exp_a << 8) | int'(ab[i])) & 32'h1FFFFF;
        end
        check_addr("mem_addr", mem_addr, sram_addr_t'(exp_a));
        host_write(REG_SRAM_DATA, 8'h77);
        host_read(REG_SRAM_DATA, rd);
        check_byte("host_rdata", rd, 8'h77);
        set_addr(32'h200);
        foreach (wb[i]) begin
            wb[i] = byte_t'(rand_bits(8));
            host_write(REG_SRAM_ADDR_INC, wb[i]);
        end
        check_addr("mem_addr", mem_addr, 21'h204);
        set_addr(32'h200);
        foreach (wb[i]) begin
            host_read(REG_SRAM_ADDR_INC, rd);
            check_byte("host_rdata", rd, wb[i]);
        end
        finish_test("host access");

        // PULSE block with plain, counted, zero and long entries
        ent_count = '{1, 3, 3, 2, 2, 4, 1};
        ent_dur = '{1 + rand_bits(5), 1 + rand_bits(4), 0, 0,
                    65536 + rand_bits(3), 1 + rand_bits(5), 1 + rand_bits(5)};
        limit = 2000;
        set_addr(0);
        foreach (ent_count[i]) begin
            limit += ent_count[i] * ent_dur[i] * TCLKS;
            if (ent_count[i] == 1 && ent_dur[i] > 0 && ent_dur[i] < 32768) begin
                put_word(ent_dur[i]);
            end else begin
                put_word(16'h8000 | ent_count[i]);
                if (ent_dur[i] >= 32768) begin
                    put_word(16'h8000 | (ent_dur[i] >> 16));
                    put_word(ent_dur[i] & 16'hFFFF);
                end else begin
                    put_word(ent_dur[i]);
                end
            end
        end
        emit_block(TAG_PULSE);
        emit_block(TAG_FULLSTOP);
        expand_pulses();
        mon_en = 1'b1;
        press_play();
        wait_playing(1'b1, 10, "play start");
        wait_playing(1'b0, limit, "end of PULSE playback");
        mon_en = 1'b0;
        if (exp_level.size() != 0) begin
            errors++;
            $display("%0d expected pulse edges never appeared", exp_level.size());
        end
        check_addr("mem_addr", mem_addr, 21'h0);
        finish_test("pulse block");

        // PAUSE block at high level
        d = 20 + rand_bits(6);
        set_addr(0);
        pause_body(1'b1, d);
        emit_block(TAG_PAUSE);
        emit_block(TAG_FULLSTOP);
        press_play();
        wait_playing(1'b1, 10, "play start");
        wait_playing(1'b0, d * TCLKS + 200, "end of PAUSE playback");
        check_level("pulse_out", pulse_out, 1'b1);
        checks++;
        if (cyc - last_edge_cyc < d * TCLKS) begin
            errors++;
            $display("Pause level changed within %0d clocks", d * TCLKS);
        end
        finish_test("pause block");

        // STOP block, then resume at the following block
        set_addr(0);
        put_word(8);
        emit_block(TAG_PULSE);
        put_word(0);
        emit_block(TAG_STOP);
        next_addr = wr_ptr;
        pause_body(1'b0, 6);
        emit_block(TAG_PAUSE);
        emit_block(TAG_FULLSTOP);
        press_play();
        wait_playing(1'b1, 10, "play start");
        wait_playing(1'b0, 500, "STOP block");
        check_addr("mem_addr", mem_addr, sram_addr_t'(next_addr));
        check_level("pulse_out", pulse_out, 1'b1);
        press_play();
        wait_playing(1'b1, 10, "resume");
        wait_playing(1'b0, 500, "end after resume");
        check_level("pulse_out", pulse_out, 1'b0);
        check_addr("mem_addr", mem_addr, 21'h0);
        finish_test("stop block");

        // stop_in mid-pulse, then a DATA tag
        set_addr(0);
        put_word(16'h8000 | 50);
        put_word(20);
        emit_block(TAG_PULSE);
        press_play();
        wait_playing(1'b1, 10, "play start");
        wait_pulse(1'b1, 200, "first pulse edge");
        repeat (5) @(posedge clk);
        #5;
        press_stop();
        wait_playing(1'b0, 3, "stop_in to end playback");
        check_addr("mem_addr", mem_addr, 21'h0);
        set_addr(0);
        pause_body(1'b0, 5);
        emit_block(TAG_PAUSE);
        put_word(16'h1234);
        put_word(16'h5678);
        emit_block(TAG_DATA);
        press_play();
        wait_playing(1'b1, 10, "play start");
        wait_playing(1'b0, 300, "DATA tag to end playback");
        check_addr("mem_addr", mem_addr, 21'h0);
        finish_test("ending playback");

        $display("Tests done, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== pzx_player_top.sv ====
`timescale 1ns/10ps

module pzx_player_top #(
    parameter int TSTATE_CLKS = pzx_pkg::TSTATE_CLKS_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  pzx_pkg::byte_t      host_addr,
    input  logic                host_rd,
    input  logic                host_wr,
    input  pzx_pkg::byte_t      host_wdata,
    output pzx_pkg::byte_t      host_rdata,
    output logic                oe_n,
    input  logic                play_in,
    input  logic                stop_in,
    output logic                pulse_out,
    output logic                playing,
    output pzx_pkg::sram_addr_t mem_addr,
    output logic                mem_we_n,
    output pzx_pkg::byte_t      mem_wdata,
    input  pzx_pkg::byte_t      mem_rdata
);
    import pzx_pkg::*;

    sram_port_if sp ();

    logic      timer_start;
    logic      timer_done;
    duration_t timer_duration;

    // SRAM data path is a straight pass between host and memory
    assign mem_wdata  = host_wdata;
    assign host_rdata = mem_rdata;

    sram_access sram_access_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_addr  (host_addr),
        .host_rd    (host_rd),
        .host_wr    (host_wr),
        .host_wdata (host_wdata),
        .playing    (playing),
        .oe_n       (oe_n),
        .mem_we_n   (mem_we_n),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .sp         (sp.mem)
    );

    pulse_timer #(
        .TSTATE_CLKS (TSTATE_CLKS)
    ) pulse_timer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (timer_start),
        .duration (timer_duration),
        .done     (timer_done)
    );

    pzx_sequencer pzx_sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .play_in        (play_in),
        .stop_in        (stop_in),
        .playing        (playing),
        .pulse_out      (pulse_out),
        .sp             (sp.seq),
        .timer_start    (timer_start),
        .timer_duration (timer_duration),
        .timer_done     (timer_done)
    );

endmodule

// ==== pzx_sequencer.sv ====
`timescale 1ns/10ps

module pzx_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               play_in,
    input  logic               stop_in,
    output logic               playing,
    output logic               pulse_out,
    sram_port_if.seq           sp,
    output logic               timer_start,
    output pzx_pkg::duration_t timer_duration,
    input  logic               timer_done
);
    import pzx_pkg::*;

    seq_state_t   state;
    pzx_tag_t     tag_q;
    block_len_t   len_q;      // Bytes left in the block body
    duration_t    dur_q;
    pulse_count_t count_q;
    logic         level_q;
    logic         playing_q;
    logic [1:0]   ed_play;
    logic [1:0]   ed_stop;
    logic         play_edge;
    logic         stop_edge;
    logic         run;
    logic         resume;
    logic         word_is_count;

    // ------------------------------
    // Play / stop edge detection
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ed_play <= 2'b00;
            ed_stop <= 2'b00;
        end else begin
            ed_play <= {ed_play[0], play_in};
            ed_stop <= {ed_stop[0], stop_in};
        end
    end

    assign play_edge = ed_play == 2'b01;
    assign stop_edge = ed_stop == 2'b01;
    assign run       = playing_q && !play_edge && !stop_edge;

    // Restart an interrupted wait when playback resumes
    assign resume = play_edge && !playing_q && !stop_edge &&
                    (state == S_PULSE_WAIT || state == S_PAUSE_WAIT);

    assign word_is_count  = dur_q[15:0] > 16'h8000;
    assign timer_duration = dur_q;
    assign playing        = playing_q;
    assign pulse_out      = level_q;

    assign sp.rewind = stop_edge ||
                       (run && ((state == S_IDLE && !sp.host_busy) || state == S_FULLSTOP));

    // ------------------------------
    // Address steps and timer starts
    // ------------------------------
    always_comb begin
        sp.step     = 1'b0;
        timer_start = resume;
        if (run) begin
            case (state)
                S_TAG, S_LEN0, S_LEN1, S_LEN2, S_LEN3,
                S_PAUSE0, S_PAUSE1, S_PAUSE2, S_PAUSE3,
                S_PULSE_W1, S_PULSE_D1, S_PULSE_L0, S_PULSE_L1: sp.step = 1'b1;
                S_PULSE_W0, S_SKIP: sp.step = len_q != '0;
                S_PULSE_CHK:        sp.step = word_is_count;
                S_PAUSE_GO,
                S_PULSE_RUN:        timer_start = dur_q != '0;
                S_PULSE_WAIT:       timer_start = timer_done && count_q != 16'd1;
                default:            sp.step = 1'b0;
            endcase
        end
    end

    // ------------------------------
    // Block parser
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            playing_q <= 1'b0;
            level_q   <= 1'b0;
            tag_q     <= TAG_FULLSTOP;
            len_q     <= '0;
            dur_q     <= '0;
            count_q   <= '0;
        end else if (stop_edge) begin
            playing_q <= 1'b0;
            state     <= S_IDLE;
        end else if (play_edge) begin
            playing_q <= ~playing_q;
        end else if (playing_q) begin
            case (state)
                S_IDLE: begin
                    if (!sp.host_busy) begin   // Rewind happens here
                        level_q <= 1'b0;
                        state   <= S_TAG;
                    end
                end
                S_TAG: begin
                    tag_q <= pzx_tag_t'(sp.rdata);
                    state <= S_LEN0;
                end
                S_LEN0: begin
                    len_q[7:0] <= sp.rdata;   // LSB first
                    state      <= S_LEN1;
                end
                S_LEN1: begin
                    len_q[15:8] <= sp.rdata;
                    state       <= S_LEN2;
                end
                S_LEN2: begin
                    len_q[23:16] <= sp.rdata;
                    state        <= S_LEN3;
                end
                S_LEN3: begin
                    len_q[31:24] <= sp.rdata;
                    case (tag_q)
                        TAG_PULSE: begin
                            level_q <= 1'b0;
                            state   <= S_PULSE_W0;
                        end
                        TAG_PAUSE: state <= S_PAUSE0;
                        TAG_STOP:  state <= S_SKIP;
                        default:   state <= S_FULLSTOP;  // FULLSTOP, DATA and unknown tags
                    endcase
                end

                S_PAUSE0: begin
                    dur_q[7:0] <= sp.rdata;
                    state      <= S_PAUSE1;
                end
                S_PAUSE1: begin
                    dur_q[15:8] <= sp.rdata;
                    state       <= S_PAUSE2;
                end
                S_PAUSE2: begin
                    dur_q[23:16] <= sp.rdata;
                    state        <= S_PAUSE3;
                end
                S_PAUSE3: begin
                    {level_q, dur_q[30:24]} <= sp.rdata;  // Bit 31 is the level
                    state                   <= S_PAUSE_GO;
                end
                S_PAUSE_GO:   state <= dur_q != '0 ? S_PAUSE_WAIT : S_TAG;
                S_PAUSE_WAIT: if (timer_done) state <= S_TAG;

                S_PULSE_W0: begin
                    if (len_q != '0) begin
                        dur_q[7:0] <= sp.rdata;
                        count_q    <= 16'd1;
                        len_q      <= len_q - 1'b1;
                        state      <= S_PULSE_W1;
                    end else begin
                        state <= S_TAG;
                    end
                end
                S_PULSE_W1: begin
                    dur_q[15:8] <= sp.rdata;
                    len_q       <= len_q - 1'b1;
                    state       <= S_PULSE_CHK;
                end
                S_PULSE_CHK: begin
                    if (word_is_count) begin   // Repeat count, duration follows
                        count_q    <= {1'b0, dur_q[14:0]};
                        dur_q[7:0] <= sp.rdata;
                        len_q      <= len_q - 1'b1;
                        state      <= S_PULSE_D1;
                    end else begin
                        state <= S_PULSE_EXT;
                    end
                end
                S_PULSE_D1: begin
                    dur_q[15:8] <= sp.rdata;
                    len_q       <= len_q - 1'b1;
                    state       <= S_PULSE_EXT;
                end
                S_PULSE_EXT: begin
                    if (dur_q[15]) begin   // Long duration, low word next
                        dur_q[30:16] <= dur_q[14:0];
                        state        <= S_PULSE_L0;
                    end else begin
                        dur_q[30:16] <= '0;
                        state        <= S_PULSE_RUN;
                    end
                end
                S_PULSE_L0: begin
                    dur_q[7:0] <= sp.rdata;
                    len_q      <= len_q - 1'b1;
                    state      <= S_PULSE_L1;
                end
                S_PULSE_L1: begin
                    dur_q[15:8] <= sp.rdata;
                    len_q       <= len_q - 1'b1;
                    state       <= S_PULSE_RUN;
                end
                S_PULSE_RUN: begin
                    if (dur_q == '0) begin
                        level_q <= level_q ^ count_q[0];
                        state   <= S_PULSE_W0;
                    end else begin
                        state <= S_PULSE_WAIT;
                    end
                end
                S_PULSE_WAIT: begin
                    if (timer_done) begin
                        level_q <= ~level_q;
                        if (count_q == 16'd1)
                            state <= S_PULSE_W0;
                        else
                            count_q <= count_q - 1'b1;   // Timer restarted in same cycle
                    end
                end

                S_SKIP: begin   // Step over the STOP body
                    if (len_q != '0)
                        len_q <= len_q - 1'b1;
                    else
                        state <= S_STOP;
                end
                S_STOP: begin
                    playing_q <= 1'b0;
                    state     <= S_TAG;   // Next play resumes at the following block
                end
                S_FULLSTOP: begin
                    playing_q <= 1'b0;
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== pulse_timer.sv ====
`timescale 1ns/10ps

module pulse_timer #(
    parameter int TSTATE_CLKS = pzx_pkg::TSTATE_CLKS_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  pzx_pkg::duration_t duration,
    output logic               done
);
    localparam int CNT_W = 34;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] target;   // duration scaled to clock cycles
    logic             running;

    assign done = running && cnt == target;

    // Counter starts at 1 so done lands exactly target cycles after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (start) begin
            running <= 1'b1;
            cnt     <= CNT_W'(1);
        end else if (done) begin
            running <= 1'b0;
        end else if (running) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            target <= CNT_W'(duration) * CNT_W'(TSTATE_CLKS);
    end

    // Zero durations are resolved in the sequencer
    a_no_zero_start: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> duration != '0
    ) else $error("timer started with zero duration");

endmodule

// ==== sram_access.sv ====
`timescale 1ns/10ps

module sram_access (
    input  logic                clk,
    input  logic                rst_n,
    input  pzx_pkg::byte_t      host_addr,
    input  logic                host_rd,
    input  logic                host_wr,
    input  pzx_pkg::byte_t      host_wdata,
    input  logic                playing,
    output logic                oe_n,
    output logic                mem_we_n,
    output pzx_pkg::sram_addr_t mem_addr,
    input  pzx_pkg::byte_t      mem_rdata,
    sram_port_if.mem            sp
);
    import pzx_pkg::*;

    host_state_t state;
    sram_addr_t  addr_q;
    logic        inc_q;      // Current access was to the auto-increment register
    logic        sel_data;
    logic        sel_inc;
    logic        sel_addr;
    logic        host_acc;

    // ------------------------------
    // Register decode and strobes
    // ------------------------------
    assign sel_inc  = host_addr == REG_SRAM_ADDR_INC;
    assign sel_data = host_addr == REG_SRAM_DATA || sel_inc;
    assign sel_addr = host_addr == REG_SRAM_ADDR;
    assign host_acc = (sel_data && (host_rd || host_wr)) || (sel_addr && host_wr);

    assign oe_n     = ~(sel_data && host_rd);
    assign mem_we_n = ~(sel_data && host_wr);
    assign mem_addr = addr_q;

    assign sp.rdata     = mem_rdata;
    assign sp.host_busy = state != H_IDLE || host_acc;

    // One count per strobe, then wait for it to drop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= H_IDLE;
            inc_q <= 1'b0;
        end else begin
            case (state)
                H_IDLE: begin
                    if (host_acc) begin
                        inc_q <= sel_inc;
                        state <= H_ACCESS;
                    end
                end
                H_ACCESS: begin
                    if (!host_rd && !host_wr)
                        state <= inc_q ? H_INCADD : H_IDLE;
                end
                H_INCADD: state <= H_IDLE;
                default:  state <= H_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Shared address register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (sp.rewind) begin
            addr_q <= '0;
        end else if (sp.step) begin
            addr_q <= addr_q + 1'b1;
        end else if (!playing) begin  // Host owns the address only when stopped
            if (state == H_IDLE && sel_addr && host_wr)
                addr_q <= {addr_q[ADDR_W-9:0], host_wdata};
            else if (state == H_INCADD)
                addr_q <= addr_q + 1'b1;
        end
    end

    // Sequencer never asks for both moves in one cycle
    a_step_rewind_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(sp.step && sp.rewind)
    ) else $error("step and rewind asserted together");

endmodule

// ==== sram_port_if.sv ====
`timescale 1ns/10ps

// Link between the block sequencer and the SRAM access unit
interface sram_port_if;
    import pzx_pkg::*;

    logic  step;       // Address + 1 at next edge
    logic  rewind;     // Address to 0 at next edge
    logic  host_busy;
    byte_t rdata;      // Byte at the current address, asynchronous

    modport seq (
        output step,
        output rewind,
        input  host_busy,
        input  rdata
    );

    modport mem (
        input  step,
        input  rewind,
        output host_busy,
        output rdata
    );

endinterface

// ==== pzx_pkg.sv ====
package pzx_pkg;

    // ------------------------------
    // Widths and basic types
    // ------------------------------
    localparam int ADDR_W = 21;

    typedef logic [ADDR_W-1:0] sram_addr_t;
    typedef logic [7:0]        byte_t;
    typedef logic [30:0]       duration_t;    // In T-states
    typedef logic [31:0]       block_len_t;
    typedef logic [15:0]       pulse_count_t;

    // Host register numbers
    typedef enum logic [7:0] {
        REG_SRAM_ADDR     = 8'hFB,  // Shift a byte into the address
        REG_SRAM_ADDR_INC = 8'hFC,  // Access, then step the address
        REG_SRAM_DATA     = 8'hFD
    } host_reg_t;

    // PZX block tags
    typedef enum logic [7:0] {
        TAG_FULLSTOP = 8'd0,
        TAG_STOP     = 8'd1,
        TAG_PULSE    = 8'd2,
        TAG_DATA     = 8'd3,
        TAG_PAUSE    = 8'd4
    } pzx_tag_t;

    // ------------------------------
    // State encodings
    // ------------------------------
    typedef enum logic [1:0] {
        H_IDLE,
        H_ACCESS,
        H_INCADD
    } host_state_t;

    typedef enum logic [4:0] {
        S_IDLE,
        S_TAG, S_LEN0, S_LEN1, S_LEN2, S_LEN3,
        S_PAUSE0, S_PAUSE1, S_PAUSE2, S_PAUSE3,
        S_PAUSE_GO, S_PAUSE_WAIT,
        S_PULSE_W0, S_PULSE_W1, S_PULSE_CHK, S_PULSE_D1,
        S_PULSE_EXT, S_PULSE_L0, S_PULSE_L1,
        S_PULSE_RUN, S_PULSE_WAIT,
        S_SKIP, S_STOP, S_FULLSTOP
    } seq_state_t;

    // Clock cycles per Z80 T-state
    localparam int TSTATE_CLKS_DEFAULT = 8;

endpackage
